/* source/isa_pkg.sv */
package isa_pkg;

    typedef logic [4:0] reg_addr_t;

    // major opcodes, RV32I base set only
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    // funct3 for OP and OP_IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // srl and sra
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3 for conditional branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // sub, sra

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        opcode_e    opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        opcode_e     opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_e    opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_addr_t   rd;
        opcode_e     opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        reg_addr_t  rd;
        opcode_e    opcode;
    } j_type_t;

    // one fetched word, seen through each format
    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } instr_u;

endpackage

/* source/core_pkg.sv */
package core_pkg;

    localparam int XLEN   = 32;
    localparam int STRB_W = XLEN / 8; // one strobe bit per byte lane

    typedef logic [XLEN-1:0] word_t;

    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_JALR,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU
    } alu_op_e;

    typedef enum logic [1:0] {
        OP1_RS1,
        OP1_PC,
        OP1_ZERO  // lui
    } op1_sel_e;

    typedef enum logic {
        OP2_RS2,
        OP2_IMM
    } op2_sel_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_sel_e;

    // same encoding as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } mem_size_e;

endpackage

/* source/rv_decoder.sv */
`timescale 1ns/100ps

module rv_decoder #(
    parameter int NUM_REGS = 32
) (
    input  isa_pkg::instr_u      inst_i,
    output isa_pkg::reg_addr_t   rs1_o,
    output isa_pkg::reg_addr_t   rs2_o,
    output isa_pkg::reg_addr_t   rd_o,
    output core_pkg::word_t      imm_o,
    output core_pkg::word_t      imm_b_o,
    output core_pkg::alu_op_e    alu_op_o,
    output core_pkg::op1_sel_e   op1_sel_o,
    output core_pkg::op2_sel_e   op2_sel_o,
    output core_pkg::wb_sel_e    wb_sel_o,
    output core_pkg::mem_size_e  mem_size_o,
    output logic                 load_unsigned_o,
    output logic                 is_load_o,
    output logic                 is_store_o,
    output logic                 is_branch_o,
    output logic                 is_jump_o,
    output logic                 rf_wen_o
);
    import isa_pkg::*;
    import core_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_j;
    word_t      imm_u;

    // shared by OP and OP_IMM
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_SR:   return alt ? ALU_SRA : ALU_SRL;
            F3_OR:   return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign opcode = inst_i.r.opcode;
    assign funct3 = inst_i.r.funct3;
    assign funct7 = inst_i.r.funct7;

    assign imm_i   = {{(XLEN-12){inst_i.i.imm[11]}}, inst_i.i.imm};
    assign imm_s   = {{(XLEN-12){inst_i.s.imm_hi[6]}}, inst_i.s.imm_hi, inst_i.s.imm_lo};
    assign imm_j   = {{(XLEN-21){inst_i.j.imm20}}, inst_i.j.imm20, inst_i.j.imm19_12,
                      inst_i.j.imm11, inst_i.j.imm10_1, 1'b0};
    assign imm_u   = {inst_i.u.imm, 12'b0};
    assign imm_b_o = {{(XLEN-13){inst_i.b.imm12}}, inst_i.b.imm12, inst_i.b.imm11,
                      inst_i.b.imm10_5, inst_i.b.imm4_1, 1'b0};

    // indices past the implemented file read as x0 and never get written
    assign rs1_o = (inst_i.r.rs1 < NUM_REGS) ? inst_i.r.rs1 : '0;
    assign rs2_o = (inst_i.r.rs2 < NUM_REGS) ? inst_i.r.rs2 : '0;
    assign rd_o  = (inst_i.r.rd < NUM_REGS) ? inst_i.r.rd : '0;

    always_comb begin
        alu_op_o        = ALU_ADD;
        op1_sel_o       = OP1_RS1;
        op2_sel_o       = OP2_IMM;
        wb_sel_o        = WB_ALU;
        mem_size_o      = mem_size_e'(funct3[1:0]);
        load_unsigned_o = funct3[2];
        imm_o           = imm_i;
        is_load_o       = 1'b0;
        is_store_o      = 1'b0;
        is_branch_o     = 1'b0;
        is_jump_o       = 1'b0;
        rf_wen_o        = 1'b0;
        case (opcode)
            OPC_OP: begin
                op2_sel_o = OP2_RS2;
                alu_op_o  = arith_op(funct3, funct7[5]);
                if (funct7 == F7_BASE ||
                    (funct7 == F7_ALT && (funct3 == F3_ADD || funct3 == F3_SR))) begin
                    rf_wen_o = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                alu_op_o = arith_op(funct3, funct7[5] && funct3 == F3_SR); // no subi
                rf_wen_o = 1'b1;
            end
            OPC_LOAD: begin
                wb_sel_o = WB_MEM;
                if (funct3[1:0] != 2'b11 && funct3 != 3'b110) begin
                    is_load_o = 1'b1;
                    rf_wen_o  = 1'b1;
                end
            end
            OPC_STORE: begin
                imm_o      = imm_s;
                is_store_o = !funct3[2] && funct3[1:0] != 2'b11;
            end
            OPC_BRANCH: begin
                op2_sel_o   = OP2_RS2;
                is_branch_o = 1'b1;
                case (funct3)
                    F3_BEQ:  alu_op_o = BR_BEQ;
                    F3_BNE:  alu_op_o = BR_BNE;
                    F3_BLT:  alu_op_o = BR_BLT;
                    F3_BGE:  alu_op_o = BR_BGE;
                    F3_BLTU: alu_op_o = BR_BLTU;
                    F3_BGEU: alu_op_o = BR_BGEU;
                    default: is_branch_o = 1'b0;
                endcase
            end
            OPC_JAL: begin
                op1_sel_o = OP1_PC;
                imm_o     = imm_j;
                wb_sel_o  = WB_PC4;
                is_jump_o = 1'b1;
                rf_wen_o  = 1'b1;
            end
            OPC_JALR: begin
                alu_op_o  = ALU_JALR;
                wb_sel_o  = WB_PC4;
                is_jump_o = (funct3 == 3'b000);
                rf_wen_o  = (funct3 == 3'b000);
            end
            OPC_LUI: begin
                op1_sel_o = OP1_ZERO;
                imm_o     = imm_u;
                rf_wen_o  = 1'b1;
            end
            OPC_AUIPC: begin
                op1_sel_o = OP1_PC;
                imm_o     = imm_u;
                rf_wen_o  = 1'b1;
            end
            default: ; // unknown opcode retires as a nop
        endcase
    end

endmodule

/* source/reg_file.sv */
`timescale 1ns/100ps

module reg_file #(
    parameter int              NUM_REGS = 32,
    parameter core_pkg::word_t SP_INIT  = 32'd1000
) (
    input  logic               clk,
    input  logic               rst_n,
    input  isa_pkg::reg_addr_t rs1_i,
    input  isa_pkg::reg_addr_t rs2_i,
    input  isa_pkg::reg_addr_t rd_i,
    input  logic               we_i,
    input  core_pkg::word_t    wdata_i,
    output core_pkg::word_t    rs1_data_o,
    output core_pkg::word_t    rs2_data_o,
    output core_pkg::word_t    gp_o
);
    import core_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= (i == 2) ? SP_INIT : '0; // x2 is sp
            end
        end else if (we_i && rd_i != '0 && rd_i < NUM_REGS) begin
            regs[rd_i] <= wdata_i;
        end
    end

    assign rs1_data_o = (rs1_i < NUM_REGS) ? regs[rs1_i] : '0;
    assign rs2_data_o = (rs2_i < NUM_REGS) ? regs[rs2_i] : '0;
    assign gp_o       = regs[3];

    // x0 only comes from reset and the write guard
    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        rs1_i == '0 |-> rs1_data_o == '0)
        else $error("x0 read back nonzero");

endmodule

/* source/alu.sv */
`timescale 1ns/100ps

module alu (
    input  core_pkg::alu_op_e  alu_op_i,
    input  core_pkg::op1_sel_e op1_sel_i,
    input  core_pkg::op2_sel_e op2_sel_i,
    input  core_pkg::word_t    rs1_data_i,
    input  core_pkg::word_t    rs2_data_i,
    input  core_pkg::word_t    pc_i,
    input  core_pkg::word_t    imm_i,
    output core_pkg::word_t    result_o,
    output logic               br_taken_o
);
    import core_pkg::*;

    word_t      op1;
    word_t      op2;
    word_t      sum;
    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    always_comb begin
        case (op1_sel_i)
            OP1_PC:   op1 = pc_i;
            OP1_ZERO: op1 = '0;
            default:  op1 = rs1_data_i;
        endcase
    end

    assign op2   = (op2_sel_i == OP2_IMM) ? imm_i : rs2_data_i;
    assign sum   = op1 + op2;
    assign shamt = op2[4:0];
    assign lt_s  = $signed(op1) < $signed(op2);
    assign lt_u  = op1 < op2;

    always_comb begin
        result_o   = '0;
        br_taken_o = 1'b0;
        case (alu_op_i)
            ALU_ADD:  result_o = sum;
            ALU_SUB:  result_o = op1 - op2;
            ALU_AND:  result_o = op1 & op2;
            ALU_OR:   result_o = op1 | op2;
            ALU_XOR:  result_o = op1 ^ op2;
            ALU_SLL:  result_o = op1 << shamt;
            ALU_SRL:  result_o = op1 >> shamt;
            ALU_SRA:  result_o = word_t'($signed(op1) >>> shamt);
            ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_u};
            ALU_JALR: result_o = {sum[XLEN-1:1], 1'b0}; // target lsb dropped
            BR_BEQ:   br_taken_o = (op1 == op2);
            BR_BNE:   br_taken_o = (op1 != op2);
            BR_BLT:   br_taken_o = lt_s;
            BR_BGE:   br_taken_o = !lt_s;
            BR_BLTU:  br_taken_o = lt_u;
            BR_BGEU:  br_taken_o = !lt_u;
            default:  ;
        endcase
    end

endmodule

/* source/load_store_unit.sv */
`timescale 1ns/100ps

module load_store_unit (
    input  core_pkg::word_t             addr_i,
    input  core_pkg::mem_size_e         mem_size_i,
    input  logic                        load_unsigned_i,
    input  core_pkg::word_t             store_data_i,
    input  core_pkg::word_t             d_rdata_i,
    output core_pkg::word_t             d_addr_o,
    output logic [core_pkg::STRB_W-1:0] d_strb_o,
    output core_pkg::word_t             d_wdata_o,
    output core_pkg::word_t             load_data_o
);
    import core_pkg::*;

    logic [1:0] offset;
    logic [4:0] lane_shift;
    word_t      rdata_shifted;
    logic       sign_b;
    logic       sign_h;

    assign offset     = addr_i[1:0];
    assign lane_shift = {offset, 3'b000}; // byte offset in bits
    assign d_addr_o   = {addr_i[XLEN-1:2], 2'b00};

    // store side
    assign d_wdata_o = store_data_i << lane_shift;

    always_comb begin
        case (mem_size_i)
            SIZE_BYTE: d_strb_o = 4'b0001 << offset;
            SIZE_HALF: d_strb_o = 4'b0011 << offset;
            default:   d_strb_o = 4'b1111;
        endcase
    end

    // load side, data arrives a cycle after the address
    assign rdata_shifted = d_rdata_i >> lane_shift;
    assign sign_b        = rdata_shifted[7] && !load_unsigned_i;
    assign sign_h        = rdata_shifted[15] && !load_unsigned_i;

    always_comb begin
        case (mem_size_i)
            SIZE_BYTE: load_data_o = {{(XLEN-8){sign_b}}, rdata_shifted[7:0]};
            SIZE_HALF: load_data_o = {{(XLEN-16){sign_h}}, rdata_shifted[15:0]};
            default:   load_data_o = d_rdata_i;
        endcase
    end

endmodule

/* source/core_control.sv */
`timescale 1ns/100ps

module core_control #(
    parameter core_pkg::word_t EXIT_ADDR = 32'h0000_1000
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            is_load_i,
    input  logic            is_store_i,
    input  logic            is_branch_i,
    input  logic            is_jump_i,
    input  logic            rf_wen_i,
    input  logic            br_taken_i,
    input  core_pkg::word_t alu_result_i,
    input  core_pkg::word_t imm_b_i,
    input  logic            d_ready_i,
    output core_pkg::word_t pc_o,
    output core_pkg::word_t pc4_o,
    output logic            rf_we_o,
    output logic            d_wen_o,
    output logic            exit_o
);
    import core_pkg::*;

    typedef enum logic [1:0] {
        ST_FETCH,
        ST_EXEC,
        ST_LOAD,
        ST_STORE
    } state_e;

    state_e state_q;
    state_e state_d;
    word_t  pc_q;
    word_t  next_pc;
    logic   retire;
    logic   wen_q;

    assign pc_o    = pc_q;
    assign pc4_o   = pc_q + 32'd4;
    assign exit_o  = (pc_q == EXIT_ADDR);
    assign d_wen_o = wen_q;
    assign rf_we_o = retire && rf_wen_i;

    always_comb begin
        state_d = state_q;
        retire  = 1'b0;
        case (state_q)
            ST_FETCH: begin
                if (!exit_o) begin
                    state_d = ST_EXEC; // parked here once at the exit address
                end
            end
            ST_EXEC: begin
                if (is_load_i) begin
                    state_d = ST_LOAD;
                end else if (is_store_i) begin
                    state_d = ST_STORE;
                end else begin
                    retire  = 1'b1;
                    state_d = ST_FETCH;
                end
            end
            ST_LOAD: begin
                retire  = 1'b1; // read data is valid now
                state_d = ST_FETCH;
            end
            default: begin
                if (d_ready_i) begin
                    retire  = 1'b1;
                    state_d = ST_FETCH;
                end
            end
        endcase
    end

    always_comb begin
        if (is_jump_i) begin
            next_pc = alu_result_i;
        end else if (is_branch_i && br_taken_i) begin
            next_pc = pc_q + imm_b_i;
        end else begin
            next_pc = pc4_o;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ST_FETCH;
            pc_q    <= '0;
            wen_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            wen_q   <= (state_d == ST_STORE);
            if (retire) begin
                pc_q <= next_pc;
            end
        end
    end

    // the store instruction must stay decoded for the whole request
    a_wen_in_store: assert property (@(posedge clk) disable iff (!rst_n)
        d_wen_o |-> state_q == ST_STORE && is_store_i && !exit_o)
        else $error("store enable outside a decoded store");

    // also catches a misaligned jump or branch target
    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        pc_q[1:0] == 2'b00)
        else $error("pc not word aligned");

endmodule

/* source/rv_core.sv */
`timescale 1ns/100ps

module rv_core #(
    parameter int              NUM_REGS  = 32,
    parameter core_pkg::word_t EXIT_ADDR = 32'h0000_1000,
    parameter core_pkg::word_t SP_INIT   = 32'd1000
) (
    input  logic                        clk,
    input  logic                        rst_n,
    output core_pkg::word_t             i_addr_o,
    input  isa_pkg::instr_u             inst_i,
    output core_pkg::word_t             d_addr_o,
    input  core_pkg::word_t             d_rdata_i,
    output logic                        d_wen_o,
    output logic [core_pkg::STRB_W-1:0] d_strb_o,
    output core_pkg::word_t             d_wdata_o,
    input  logic                        d_ready_i,
    output logic                        exit_o,
    output core_pkg::word_t             gp_o
);
    import isa_pkg::*;
    import core_pkg::*;

    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;
    word_t     imm_b;
    alu_op_e   alu_op;
    op1_sel_e  op1_sel;
    op2_sel_e  op2_sel;
    wb_sel_e   wb_sel;
    mem_size_e mem_size;
    logic      load_unsigned;
    logic      is_load;
    logic      is_store;
    logic      is_branch;
    logic      is_jump;
    logic      rf_wen;
    logic      rf_we;
    logic      br_taken;
    word_t     pc;
    word_t     pc4;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     alu_result;
    word_t     load_data;
    word_t     wb_data;

    assign i_addr_o = pc;

    always_comb begin
        case (wb_sel)
            WB_MEM:  wb_data = load_data;
            WB_PC4:  wb_data = pc4; // link value
            default: wb_data = alu_result;
        endcase
    end

    core_control #(
        .EXIT_ADDR (EXIT_ADDR)
    ) u_control (
        .clk          (clk),
        .rst_n        (rst_n),
        .is_load_i    (is_load),
        .is_store_i   (is_store),
        .is_branch_i  (is_branch),
        .is_jump_i    (is_jump),
        .rf_wen_i     (rf_wen),
        .br_taken_i   (br_taken),
        .alu_result_i (alu_result),
        .imm_b_i      (imm_b),
        .d_ready_i    (d_ready_i),
        .pc_o         (pc),
        .pc4_o        (pc4),
        .rf_we_o      (rf_we),
        .d_wen_o      (d_wen_o),
        .exit_o       (exit_o)
    );

    rv_decoder #(
        .NUM_REGS (NUM_REGS)
    ) u_decoder (
        .inst_i          (inst_i),
        .rs1_o           (rs1),
        .rs2_o           (rs2),
        .rd_o            (rd),
        .imm_o           (imm),
        .imm_b_o         (imm_b),
        .alu_op_o        (alu_op),
        .op1_sel_o       (op1_sel),
        .op2_sel_o       (op2_sel),
        .wb_sel_o        (wb_sel),
        .mem_size_o      (mem_size),
        .load_unsigned_o (load_unsigned),
        .is_load_o       (is_load),
        .is_store_o      (is_store),
        .is_branch_o     (is_branch),
        .is_jump_o       (is_jump),
        .rf_wen_o        (rf_wen)
    );

    reg_file #(
        .NUM_REGS (NUM_REGS),
        .SP_INIT  (SP_INIT)
    ) u_reg_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .rd_i       (rd),
        .we_i       (rf_we),
        .wdata_i    (wb_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .gp_o       (gp_o)
    );

    alu u_alu (
        .alu_op_i   (alu_op),
        .op1_sel_i  (op1_sel),
        .op2_sel_i  (op2_sel),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .pc_i       (pc),
        .imm_i      (imm),
        .result_o   (alu_result),
        .br_taken_o (br_taken)
    );

    load_store_unit u_lsu (
        .addr_i          (alu_result),
        .mem_size_i      (mem_size),
        .load_unsigned_i (load_unsigned),
        .store_data_i    (rs2_data),
        .d_rdata_i       (d_rdata_i),
        .d_addr_o        (d_addr_o),
        .d_strb_o        (d_strb_o),
        .d_wdata_o       (d_wdata_o),
        .load_data_o     (load_data)
    );

    // checked on a store beat or a retiring load, where the address is settled
    a_mem_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (d_wen_o || (rf_we && wb_sel == WB_MEM)) |->
            !(mem_size == SIZE_HALF && alu_result[0]) &&
            !(mem_size == SIZE_WORD && alu_result[1:0] != 2'b00))
        else $error("misaligned data access at %h", alu_result);

endmodule

/* testbench/tb_rv_core.sv */
`timescale 1ns/100ps

module tb_rv_core;

    localparam int ROM_WORDS = 2048;
    localparam int RAM_WORDS = 256;
    localparam int HDR_BASE  = 'h00; // header: prog words, data words, records, gp, executed
    localparam int PROG_BASE = 'h10;
    localparam int DATA_BASE = 'h70;
    localparam int REC_BASE  = 'h80; // address, strobe, data per record

    logic        clk;
    logic        rst_n;
    logic [31:0] i_addr_o;
    logic [31:0] inst_i;
    logic [31:0] d_addr_o;
    logic [31:0] d_rdata_i;
    logic        d_wen_o;
    logic [3:0]  d_strb_o;
    logic [31:0] d_wdata_o;
    logic        d_ready_i;
    logic        exit_o;
    logic [31:0] gp_o;

    logic [31:0] stim [0:255];
    logic [31:0] rom [0:ROM_WORDS-1];
    logic [31:0] ram [0:RAM_WORDS-1];

    int          value_errors;
    int          protocol_errors;
    int          n_stores;
    int          n_records;
    int          n_executed;
    int          low_left;
    logic [31:0] rng_state;
    logic        stall_prev;
    logic [31:0] prev_addr;
    logic [3:0]  prev_strb;
    logic [31:0] prev_wdata;

    rv_core u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_addr_o  (i_addr_o),
        .inst_i    (inst_i),
        .d_addr_o  (d_addr_o),
        .d_rdata_i (d_rdata_i),
        .d_wen_o   (d_wen_o),
        .d_strb_o  (d_strb_o),
        .d_wdata_o (d_wdata_o),
        .d_ready_i (d_ready_i),
        .exit_o    (exit_o),
        .gp_o      (gp_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] byte_mask(input logic [3:0] strb);
        return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp === act)
        else begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    // instruction rom reads combinationally
    assign inst_i = rom[i_addr_o[12:2]];

    // data ram, store handshake and ready back-pressure
    always @(posedge clk) begin
        logic [7:0]  idx;
        logic [31:0] mask;
        logic [31:0] exp_mask;
        idx = d_addr_o[9:2];
        d_rdata_i <= ram[idx];
        if (rst_n) begin
            if (stall_prev) begin
                assert (d_wen_o && d_addr_o === prev_addr && d_strb_o === prev_strb &&
                        d_wdata_o === prev_wdata)
                else begin
                    $display("store request changed while ready was low at %0t", $time);
                    protocol_errors++;
                end
            end
            if (d_wen_o && d_ready_i) begin
                mask = byte_mask(d_strb_o);
                assert (n_stores < n_records)
                else begin
                    $display("unexpected extra store to %h", d_addr_o);
                    protocol_errors++;
                end
                if (n_stores < n_records) begin
                    exp_mask = byte_mask(stim[REC_BASE + 3*n_stores + 1][3:0]);
                    check_value($sformatf("store %0d address", n_stores),
                                stim[REC_BASE + 3*n_stores], d_addr_o);
                    check_value($sformatf("store %0d strobe", n_stores),
                                stim[REC_BASE + 3*n_stores + 1], {28'b0, d_strb_o});
                    check_value($sformatf("store %0d data", n_stores),
                                stim[REC_BASE + 3*n_stores + 2] & exp_mask,
                                d_wdata_o & exp_mask);
                end
                n_stores++;
                ram[idx] <= (ram[idx] & ~mask) | (d_wdata_o & mask);
                rng_state = xorshift32(rng_state);
                low_left  = rng_state % 4; // next store waits 0 to 3 cycles
            end else if (d_wen_o && !d_ready_i && low_left > 0) begin
                low_left--;
            end
            stall_prev = d_wen_o && !d_ready_i;
            prev_addr  = d_addr_o;
            prev_strb  = d_strb_o;
            prev_wdata = d_wdata_o;
            d_ready_i <= (low_left == 0);
        end
    end

    // watchdog sized from the executed instruction count
    initial begin
        #1;
        repeat (n_executed * 6 + 50) @(posedge clk);
        $display("timeout: the core did not reach the exit address in time");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        rst_n           = 1'b0;
        d_ready_i       = 1'b0;
        d_rdata_i       = '0;
        value_errors    = 0;
        protocol_errors = 0;
        n_stores        = 0;
        stall_prev      = 1'b0;
        rng_state       = 32'd85;
        $readmemh("testbench/core_stim.mem", stim);
        n_records  = stim[HDR_BASE + 2];
        n_executed = stim[HDR_BASE + 4];
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = i << 16; // opcode 0, decodes as a nop
        end
        for (int i = 0; i < stim[HDR_BASE]; i++) begin
            rom[i] = stim[PROG_BASE + i];
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram[i] = 32'hA500_0000 ^ (i * 32'h0001_0101);
        end
        for (int i = 0; i < stim[HDR_BASE + 1]; i++) begin
            ram[i] = stim[DATA_BASE + i];
        end
        rng_state = xorshift32(rng_state);
        low_left  = rng_state % 4;

        repeat (9) @(posedge clk);
        @(negedge clk);
        check_value("reset exit", 32'd0, {31'b0, exit_o});
        check_value("reset d_wen", 32'd0, {31'b0, d_wen_o});
        check_value("reset pc", 32'd0, i_addr_o);
        check_value("reset gp", 32'd0, gp_o);
        @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        while (!exit_o) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk); // no store may follow the exit
        check_value("exit held", 32'd1, {31'b0, exit_o});
        check_value("final gp", stim[HDR_BASE + 3], gp_o);
        check_value("store count", n_records, n_stores);

        $display("checks done: %0d value errors, %0d protocol errors",
                 value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* testbench/core_stim.mem */
// header @00: program words, data words, store records, expected gp, executed count
// program @10, data words @70, store records @80 as address strobe data
@00
00000054 00000002 00000020 1234D10D 0000004B
@10
10000513 FFB00093 00300113 002082B3 00552023 402082B3 00552223 0020F2B3
00552423 0020E2B3 00552623 0020C2B3 00552823 002092B3 00552A23 0020D2B3
00552C23 4020D2B3 00552E23 0020A2B3 02552023 0020B2B3 02552223 FFC0A293
02552423 FFC0B293 02552623 4010D293 02552823 0F00C293 02552A23 ABCDE2B7
02552C23 00001297 02552E23 00300303 04650023 00204303 046500A3 00100303
04650123 00004303 046501A3 00201383 04751223 00205383 04751323 00001383
04752423 00402403 04852623 00208463 04252823 00108463 06052E23 00209463
06052E23 00109463 04252A23 0020C463 06052E23 0010C463 04252C23 0020D463
04252E23 0010D463 06052E23 0020E463 06252023 00116463 06052E23 0020F463
06052E23 00117463 06252223 00C0066F 06052E23 06052E23 06C52423 014606E7
06052E23 06D52623 007401B3 6B50006F
@70
8CF07A95 12345678
@80
00000100 0000000F FFFFFFFE  00000104 0000000F FFFFFFF8  00000108 0000000F 00000003
0000010C 0000000F FFFFFFFB  00000110 0000000F FFFFFFF8  00000114 0000000F FFFFFFD8
00000118 0000000F 1FFFFFFF  0000011C 0000000F FFFFFFFF  00000120 0000000F 00000001
00000124 0000000F 00000000  00000128 0000000F 00000001  0000012C 0000000F 00000001
00000130 0000000F FFFFFFFD  00000134 0000000F FFFFFF0B  00000138 0000000F ABCDE000
0000013C 0000000F 00001084  00000140 00000001 0000008C  00000140 00000002 0000F000
00000140 00000004 007A0000  00000140 00000008 95000000  00000144 00000003 00008CF0
00000144 0000000C 8CF00000  00000148 0000000F 00007A95  0000014C 0000000F 12345678
00000150 0000000F 00000003  00000154 0000000F 00000003  00000158 0000000F 00000003
0000015C 0000000F 00000003  00000160 0000000F 00000003  00000164 0000000F 00000003
00000168 0000000F 00000130  0000016C 0000000F 00000140

/* all.f */
source/isa_pkg.sv
source/core_pkg.sv
source/rv_decoder.sv
source/reg_file.sv
source/alu.sv
source/load_store_unit.sv
source/core_control.sv
source/rv_core.sv
testbench/tb_rv_core.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - source/isa_pkg.sv
  - source/core_pkg.sv
  - source/rv_decoder.sv
  - source/reg_file.sv
  - source/alu.sv
  - source/load_store_unit.sv
  - source/core_control.sv
  - source/rv_core.sv
  - target: simulation
    files:
      - testbench/tb_rv_core.sv
